//--- hw/lsuPkg.sv
// Shared widths and types of the load/store unit, compiled ahead of every RTL and testbench file
package lsuPkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  parameter int Xlen      = 64;       // Data and address width in bits
  parameter int LaneCount = Xlen / 8; // Byte lanes per word

  typedef logic [Xlen-1:0]      xWordT;    // One data or address word
  typedef logic [LaneCount-1:0] byteMaskT; // Write enable per byte lane

  ////////////////////////////////////////
  // Access control
  ////////////////////////////////////////

  // Same bit order as the pipeline MemRW field, read in the upper bit
  typedef struct packed {
    logic read;  // Load, LR, or the read half of an atomic
    logic write; // Store or SC
  } memRwT;

  // Low two bits of funct3 for loads and stores
  typedef enum logic [1:0] {
    sizeByte   = 2'b00,
    sizeHalf   = 2'b01,
    sizeWord   = 2'b10,
    sizeDouble = 2'b11
  } accessSizeT;

  // Full funct3, bit 2 selects zero extension on loads
  typedef struct packed {
    logic       unsignedLoad; // lbu, lhu, lwu
    accessSizeT size;
  } funct3T;

  // Only LR/SC survive from the A extension
  typedef enum logic [1:0] {
    atomNone = 2'b00,
    atomSc   = 2'b01,
    atomLr   = 2'b10
  } atomicT;

  ////////////////////////////////////////
  // Memory word
  ////////////////////////////////////////

  // A DTIM row seen whole or lane by lane
  typedef union packed {
    xWordT                       dword; // Full doubleword
    logic [LaneCount-1:0][7:0]   lanes; // Lane 0 holds the lowest address byte
  } memWordU;

endpackage

//--- hw/lsuCtrl.sv
// LSU control path with the E-to-M address register, misalignment faults and LR/SC reservation
`timescale 1ns/1ps

module lsuCtrl (
  input  logic           clk,
  input  logic           arstN,
  input  logic           StallM,                   // Hold the M stage
  input  logic           FlushM,                   // Kill what enters M
  input  logic           StallW,                   // Hold the W stage and the DTIM
  input  logic           FlushW,                   // Kill the access in M
  input  lsuPkg::xWordT  IEUAdrE,                  // Address computed in E
  input  lsuPkg::memRwT  MemRWM,                   // Raw read/write request in M
  input  lsuPkg::funct3T Funct3M,                  // Size and extension of the access
  input  lsuPkg::atomicT AtomicM,                  // LR/SC marker
  output lsuPkg::xWordT  IEUAdrM,                  // Address in M
  output lsuPkg::memRwT  lsuRwM,                   // Command actually sent to the DTIM
  output logic           dtimCe,                   // DTIM clock enable
  output logic           LoadMisalignedFaultM,
  output logic           StoreAmoMisalignedFaultM,
  output logic           SquashSCW                 // SC failed, no write to the register file
);

  localparam int ResBits = lsuPkg::Xlen - 3; // Doubleword granule of the reservation

  logic               misalignedM;  // Low address bits do not fit the size
  logic               lrM;          // LR in M
  logic               scM;          // SC in M
  logic               resMatchM;    // Reservation covers this doubleword
  logic               scFailM;      // SC without a matching reservation
  logic               resUpdate;    // M retires into W this edge
  logic               resValid;
  logic [ResBits-1:0] resAdr;

  ////////////////////////////////////////
  // E to M address register
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      IEUAdrM <= '0;
    end else if (!StallM) begin
      IEUAdrM <= FlushM ? '0 : IEUAdrE; // Flush leaves a zero address in M
    end
  end

  ////////////////////////////////////////
  // Misalignment
  ////////////////////////////////////////

  always_comb begin
    case (Funct3M.size)
      lsuPkg::sizeHalf:   misalignedM = IEUAdrM[0];
      lsuPkg::sizeWord:   misalignedM = |IEUAdrM[1:0];
      lsuPkg::sizeDouble: misalignedM = |IEUAdrM[2:0];
      default:            misalignedM = 1'b0; // Bytes always fit
    endcase
  end

  // An access with a write side reports as store/AMO
  assign LoadMisalignedFaultM     = misalignedM & MemRWM.read & ~MemRWM.write;
  assign StoreAmoMisalignedFaultM = misalignedM & MemRWM.write;

  ////////////////////////////////////////
  // LR/SC reservation
  ////////////////////////////////////////

  assign lrM       = MemRWM.read & (AtomicM == lsuPkg::atomLr) & ~misalignedM;
  assign scM       = MemRWM.write & (AtomicM == lsuPkg::atomSc);
  assign resMatchM = resValid & (resAdr == IEUAdrM[lsuPkg::Xlen-1:3]);
  assign scFailM   = scM & ~resMatchM;
  assign resUpdate = ~StallW & ~FlushW; // Flushed accesses leave the reservation alone

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      resValid <= 1'b0;
    end else if (resUpdate) begin
      if (scM) begin
        resValid <= 1'b0;       // Any SC consumes the reservation
      end else if (lrM) begin
        resValid <= 1'b1;
      end
    end
  end

  // Reserved doubleword, only meaningful while resValid is set
  always_ff @(posedge clk) begin
    if (resUpdate && lrM && !scM) begin
      resAdr <= IEUAdrM[lsuPkg::Xlen-1:3];
    end
  end

  // Failed SC travels to W with the read data
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      SquashSCW <= 1'b0;
    end else if (!StallW) begin
      SquashSCW <= scFailM;
    end
  end

  ////////////////////////////////////////
  // Memory command
  ////////////////////////////////////////

  assign lsuRwM = (misalignedM | FlushW | scFailM) ? '0 : MemRWM; // Drop faulting or dead accesses
  assign dtimCe = ~StallW;

endmodule

//--- hw/storeFormat.sv
// Store formatter that replicates store data into its lanes and builds the byte write mask
`timescale 1ns/1ps

module storeFormat (
  input  lsuPkg::xWordT    IEUAdrM,    // Low bits pick the lanes
  input  lsuPkg::funct3T   Funct3M,
  input  logic             BigEndianM, // Swap lanes for this access
  input  lsuPkg::xWordT    WriteDataM, // Register value, data in the low bits
  output lsuPkg::memWordU  writeWordM, // Word as laid out in the DTIM
  output lsuPkg::byteMaskT byteMaskM   // Lanes to write
);

  lsuPkg::xWordT    replDataM; // Little-endian replicated data
  lsuPkg::xWordT    swapDataM; // Same, lanes reversed
  lsuPkg::byteMaskT leMaskM;   // Little-endian lane mask
  lsuPkg::byteMaskT swapMaskM; // Same, bits reversed

  ////////////////////////////////////////
  // Replication and mask
  ////////////////////////////////////////

  always_comb begin
    case (Funct3M.size)
      lsuPkg::sizeByte: begin
        replDataM = {8{WriteDataM[7:0]}};
        leMaskM   = lsuPkg::byteMaskT'(8'h01) << IEUAdrM[2:0];
      end
      lsuPkg::sizeHalf: begin
        replDataM = {4{WriteDataM[15:0]}};
        leMaskM   = lsuPkg::byteMaskT'(8'h03) << {IEUAdrM[2:1], 1'b0};
      end
      lsuPkg::sizeWord: begin
        replDataM = {2{WriteDataM[31:0]}};
        leMaskM   = lsuPkg::byteMaskT'(8'h0f) << {IEUAdrM[2], 2'b00};
      end
      default: begin
        replDataM = WriteDataM;                 // Double fills every lane
        leMaskM   = '1;
      end
    endcase
  end

  ////////////////////////////////////////
  // Big-endian swap
  ////////////////////////////////////////

  // Lane i moves to lane 7-i, mask bits follow the lanes
  assign swapDataM = {<<8{replDataM}};
  assign swapMaskM = {<<{leMaskM}};

  always_comb begin
    writeWordM.dword = BigEndianM ? swapDataM : replDataM;
    byteMaskM        = BigEndianM ? swapMaskM : leMaskM;
  end

endmodule

//--- hw/loadFormat.sv
// Load formatter that undoes big-endian order, picks the addressed lanes, extends and registers them
`timescale 1ns/1ps

module loadFormat (
  input  logic            clk,
  input  logic            arstN,
  input  logic            StallW,     // Hold the W register
  input  lsuPkg::xWordT   IEUAdrM,
  input  lsuPkg::funct3T  Funct3M,
  input  logic            BigEndianM,
  input  lsuPkg::memWordU readWordM,  // Raw DTIM row
  output lsuPkg::xWordT   ReadDataW   // Load result in W
);

  lsuPkg::xWordT   swapWordM; // Row with lanes reversed
  lsuPkg::memWordU leWordM;   // Row in little-endian lane order
  logic [7:0]      byteM;
  logic [15:0]     halfM;
  logic [31:0]     wordM;
  logic            signM;     // Sign extension enabled
  lsuPkg::xWordT   readDataM; // Formatted result in M

  ////////////////////////////////////////
  // Swap and lane select
  ////////////////////////////////////////

  assign swapWordM = {<<8{readWordM.dword}};

  always_comb begin
    leWordM.dword = BigEndianM ? swapWordM : readWordM.dword;
  end

  // Pick lanes by offset, higher lane is the more significant byte
  assign byteM = leWordM.lanes[IEUAdrM[2:0]];
  assign halfM = {leWordM.lanes[{IEUAdrM[2:1], 1'b1}],
                  leWordM.lanes[{IEUAdrM[2:1], 1'b0}]};
  assign wordM = {leWordM.lanes[{IEUAdrM[2], 2'b11}], leWordM.lanes[{IEUAdrM[2], 2'b10}],
                  leWordM.lanes[{IEUAdrM[2], 2'b01}], leWordM.lanes[{IEUAdrM[2], 2'b00}]};

  ////////////////////////////////////////
  // Extension
  ////////////////////////////////////////

  assign signM = ~Funct3M.unsignedLoad;

  always_comb begin
    case (Funct3M.size)
      lsuPkg::sizeByte:   readDataM = {{56{signM & byteM[7]}}, byteM};
      lsuPkg::sizeHalf:   readDataM = {{48{signM & halfM[15]}}, halfM};
      lsuPkg::sizeWord:   readDataM = {{32{signM & wordM[31]}}, wordM};
      default:            readDataM = leWordM.dword;                     // ld
    endcase
  end

  // M to W read data register
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ReadDataW <= '0;
    end else if (!StallW) begin
      ReadDataW <= readDataM;
    end
  end

endmodule

//--- hw/dtim.sv
// Tightly coupled data memory with synchronous read and byte-masked write, addressed from E or M
`timescale 1ns/1ps

module dtim #(
  parameter int DtimWords = 256 // Depth in doublewords
) (
  input  logic             clk,
  input  logic             dtimCe,     // Whole array held when low
  input  lsuPkg::memRwT    MemRWE,     // Request of the access in E
  input  lsuPkg::memRwT    lsuRwM,     // Filtered command of the access in M
  input  lsuPkg::xWordT    IEUAdrE,
  input  lsuPkg::xWordT    IEUAdrM,
  input  lsuPkg::memWordU  writeWordM, // Lane-aligned store data
  input  lsuPkg::byteMaskT byteMaskM,
  output lsuPkg::memWordU  readWordM   // Row read for the access now in M
);

  localparam int AdrBits = $clog2(DtimWords);

  lsuPkg::memWordU    mem [DtimWords]; // Storage rows
  logic [AdrBits-1:0] dtimAdr;         // Row index

  ////////////////////////////////////////
  // Address mux
  ////////////////////////////////////////

  // Stores in M own the port, otherwise E reads ahead
  assign dtimAdr = lsuRwM.write ? IEUAdrM[AdrBits+2:3] : IEUAdrE[AdrBits+2:3];

  ////////////////////////////////////////
  // Array
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (dtimCe) begin
      if (lsuRwM.write) begin
        for (int i = 0; i < lsuPkg::LaneCount; i++) begin
          if (byteMaskM[i]) begin
            mem[dtimAdr].lanes[i] <= writeWordM.lanes[i]; // Untouched lanes keep their bytes
          end
        end
      end else if (MemRWE.read) begin
        readWordM <= mem[dtimAdr];                        // Ready while the load sits in M
      end
    end
  end

endmodule

//--- hw/lsuTop.sv
// Top level of the DTIM load/store unit, connects control, store format, memory and load format
`timescale 1ns/1ps

module lsuTop #(
  parameter int DtimWords = 256 // DTIM depth in doublewords
) (
  input  logic           clk,
  input  logic           arstN,
  // Stage controls
  input  logic           StallM,
  input  logic           FlushM,
  input  logic           StallW,
  input  logic           FlushW,
  // Execute stage
  input  lsuPkg::memRwT  MemRWE,
  input  lsuPkg::xWordT  IEUAdrE,
  // Memory stage
  input  lsuPkg::memRwT  MemRWM,
  input  lsuPkg::funct3T Funct3M,
  input  lsuPkg::atomicT AtomicM,
  input  logic           BigEndianM,
  input  lsuPkg::xWordT  WriteDataM,
  // Results
  output lsuPkg::xWordT  IEUAdrM,
  output lsuPkg::xWordT  ReadDataW,
  output logic           LoadMisalignedFaultM,
  output logic           StoreAmoMisalignedFaultM,
  output logic           SquashSCW
);

  lsuPkg::memRwT    lsuRwM;     // Gated command to the DTIM
  logic             dtimCe;
  lsuPkg::memWordU  writeWordM; // Formatted store row
  lsuPkg::byteMaskT byteMaskM;
  lsuPkg::memWordU  readWordM;  // Raw load row

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////

  lsuCtrl u_lsuCtrl (
    .clk                     (clk),
    .arstN                   (arstN),
    .StallM                  (StallM),
    .FlushM                  (FlushM),
    .StallW                  (StallW),
    .FlushW                  (FlushW),
    .IEUAdrE                 (IEUAdrE),
    .MemRWM                  (MemRWM),
    .Funct3M                 (Funct3M),
    .AtomicM                 (AtomicM),
    .IEUAdrM                 (IEUAdrM),
    .lsuRwM                  (lsuRwM),
    .dtimCe                  (dtimCe),
    .LoadMisalignedFaultM    (LoadMisalignedFaultM),
    .StoreAmoMisalignedFaultM(StoreAmoMisalignedFaultM),
    .SquashSCW               (SquashSCW)
  );

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////

  storeFormat u_storeFormat (
    .IEUAdrM   (IEUAdrM),
    .Funct3M   (Funct3M),
    .BigEndianM(BigEndianM),
    .WriteDataM(WriteDataM),
    .writeWordM(writeWordM),
    .byteMaskM (byteMaskM)
  );

  dtim #(
    .DtimWords(DtimWords)
  ) u_dtim (
    .clk       (clk),
    .dtimCe    (dtimCe),
    .MemRWE    (MemRWE),
    .lsuRwM    (lsuRwM),
    .IEUAdrE   (IEUAdrE),
    .IEUAdrM   (IEUAdrM),
    .writeWordM(writeWordM),
    .byteMaskM (byteMaskM),
    .readWordM (readWordM)
  );

  loadFormat u_loadFormat (
    .clk       (clk),
    .arstN     (arstN),
    .StallW    (StallW),
    .IEUAdrM   (IEUAdrM),
    .Funct3M   (Funct3M),
    .BigEndianM(BigEndianM),
    .readWordM (readWordM),
    .ReadDataW (ReadDataW)
  );

endmodule

//--- sim/lsuCtrl_chk.sv
// Concurrent assertions on the LSU control unit, bound into every lsuCtrl instance
`timescale 1ns/1ps

module lsuCtrl_chk (
  input logic           clk,
  input logic           arstN,
  input lsuPkg::memRwT  MemRWM,
  input lsuPkg::atomicT AtomicM,
  input lsuPkg::memRwT  lsuRwM,                   // Command seen by the DTIM
  input logic           LoadMisalignedFaultM,
  input logic           StoreAmoMisalignedFaultM,
  input logic           SquashSCW
);

  int failCount = 0; // Assertion failures so far

  ////////////////////////////////////////
  // Fault gating
  ////////////////////////////////////////

  // Faulting access never reaches the array
  noWriteOnFault: assert property (@(posedge clk) disable iff (!arstN)
    (LoadMisalignedFaultM || StoreAmoMisalignedFaultM) |-> !lsuRwM.write)
    else begin
      failCount++;
      $error("DTIM write issued while a misalignment fault is raised");
    end

  oneFaultKind: assert property (@(posedge clk) disable iff (!arstN)
    !(LoadMisalignedFaultM && StoreAmoMisalignedFaultM))
    else begin
      failCount++;
      $error("Load and store misalignment faults raised together");
    end

  ////////////////////////////////////////
  // SC squash timing
  ////////////////////////////////////////

  // Squash only follows an SC in M by one edge
  squashAfterSc: assert property (@(posedge clk) disable iff (!arstN)
    $rose(SquashSCW) |-> $past(MemRWM.write && AtomicM == lsuPkg::atomSc))
    else begin
      failCount++;
      $error("SquashSCW rose without an SC in M on the previous edge");
    end

endmodule

bind lsuCtrl lsuCtrl_chk u_lsuCtrlChk (
  .clk                     (clk),
  .arstN                   (arstN),
  .MemRWM                  (MemRWM),
  .AtomicM                 (AtomicM),
  .lsuRwM                  (lsuRwM),
  .LoadMisalignedFaultM    (LoadMisalignedFaultM),
  .StoreAmoMisalignedFaultM(StoreAmoMisalignedFaultM),
  .SquashSCW               (SquashSCW)
);

//--- sim/lsuTb.sv
// Directed testbench for the DTIM load/store unit, plays E and M stages against a byte-level memory model
`timescale 1ns/1ps

module lsuTb;

  localparam int DtimWords    = 64;  // Smaller DTIM keeps the model short
  localparam int ModelBytes   = 128; // Tests touch doublewords 0 to 15 only
  localparam int ResetTimeout = 20;  // Cycles allowed for outputs to clear

  localparam lsuPkg::memRwT RwRead  = '{read: 1'b1, write: 1'b0};
  localparam lsuPkg::memRwT RwWrite = '{read: 1'b0, write: 1'b1};

  // One access as it moves through E, M and W
  typedef struct packed {
    lsuPkg::memRwT  rw;
    lsuPkg::funct3T f3;
    lsuPkg::atomicT atom;
    logic           be;     // Big-endian byte order
    logic           flushM; // Killed on its way into M
    logic           flushW; // Killed while in M
    logic           stallW; // W held while this slot is in M
    lsuPkg::xWordT  adr;
    lsuPkg::xWordT  data;
  } opT;

  logic clk;
  logic arstN;
  logic StallM;
  logic FlushM;
  logic StallW;
  logic FlushW;
  lsuPkg::memRwT  MemRWE;
  lsuPkg::xWordT  IEUAdrE;
  lsuPkg::memRwT  MemRWM;
  lsuPkg::funct3T Funct3M;
  lsuPkg::atomicT AtomicM;
  logic           BigEndianM;
  lsuPkg::xWordT  WriteDataM;
  lsuPkg::xWordT  IEUAdrM;
  lsuPkg::xWordT  ReadDataW;
  logic           LoadMisalignedFaultM;
  logic           StoreAmoMisalignedFaultM;
  logic           SquashSCW;

  opT                          ops[$];          // Program waiting to be played
  logic [7:0]                  model [ModelBytes];
  logic                        resValid;        // Reservation model
  logic [lsuPkg::Xlen-4:0]     resDword;
  lsuPkg::xWordT               lastRead;        // Last load result expected in W
  logic                        lastValid;
  integer                      seed = 32'h72b59181;
  int                          checkCount = 0;
  int                          errCount = 0;
  int                          errStart;
  int                          assertFails;
  string                       curTest;

  lsuTop #(
    .DtimWords(DtimWords)
  ) u_lsuTop (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk; // 8 ns period
  end

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic checkWord(string what, lsuPkg::xWordT expected, lsuPkg::xWordT actual);
    checkCount++;
    if (actual !== expected) begin
      errCount++;
      $display("[FAIL] %s %s expected %h actual %h", curTest, what, expected, actual);
    end
  endtask

  task automatic checkFlag(string what, logic expected, logic actual);
    checkCount++;
    if (actual !== expected) begin
      errCount++;
      $display("[FAIL] %s %s expected %b actual %b", curTest, what, expected, actual);
    end
  endtask

  ////////////////////////////////////////
  // Memory and reservation model
  ////////////////////////////////////////

  // Big-endian mirrors the offset inside the doubleword
  function automatic int byteAddr(lsuPkg::xWordT adr, int k, logic be);
    int a;
    a = int'(adr[6:0]);
    if (be) return (a & ~7) + 7 - ((a & 7) + k);
    return a + k;
  endfunction

  function automatic logic isMisaligned(opT op);
    int n;
    n = 1 << int'(op.f3.size);
    return (op.rw.read | op.rw.write) && (int'(op.adr[2:0]) % n != 0);
  endfunction

  function automatic lsuPkg::xWordT modelLoad(opT op);
    int            n;
    lsuPkg::xWordT v;
    n = 1 << int'(op.f3.size);
    v = '0;
    for (int k = 0; k < n; k++) v[8*k +: 8] = model[byteAddr(op.adr, k, op.be)];
    if (!op.f3.unsignedLoad) begin
      for (int b = 8 * n; b < 64; b++) v[b] = v[8*n-1]; // Sign fill
    end
    return v;
  endfunction

  task automatic writeModel(opT op);
    int n;
    n = 1 << int'(op.f3.size);
    for (int k = 0; k < n; k++) model[byteAddr(op.adr, k, op.be)] = op.data[8*k +: 8];
  endtask

  ////////////////////////////////////////
  // Program building
  ////////////////////////////////////////

  function automatic opT makeOp(lsuPkg::memRwT rw, lsuPkg::accessSizeT size, logic uns,
                                lsuPkg::atomicT atom, logic be, int adr, lsuPkg::xWordT data);
    opT op;
    op                 = '0;
    op.rw              = rw;
    op.f3.size         = size;
    op.f3.unsignedLoad = uns;
    op.atom            = atom;
    op.be              = be;
    op.adr             = lsuPkg::xWordT'(adr);
    op.data            = data;
    return op;
  endfunction

  function automatic lsuPkg::xWordT randWord();
    return {$random(seed), $random(seed)};
  endfunction

  // A load may not sit in E behind a store in M, so a bubble goes between
  task automatic pushOp(opT op);
    opT gap;
    gap = '0;
    if (op.rw.read && ops.size() > 0 && ops[$].rw.write) ops.push_back(gap);
    ops.push_back(op);
  endtask

  task automatic pushLoad(lsuPkg::accessSizeT size, logic uns, logic be, int adr);
    pushOp(makeOp(RwRead, size, uns, lsuPkg::atomNone, be, adr, '0));
  endtask

  task automatic pushStore(lsuPkg::accessSizeT size, logic be, int adr, lsuPkg::xWordT data);
    pushOp(makeOp(RwWrite, size, 1'b0, lsuPkg::atomNone, be, adr, data));
  endtask

  task automatic pushIdle(logic stall);
    opT op;
    op        = '0;
    op.stallW = stall;
    ops.push_back(op);
  endtask

  ////////////////////////////////////////
  // Pipeline player
  ////////////////////////////////////////

  task automatic driveSlots(opT eOp, opT mOp);
    MemRWE  = eOp.rw;
    IEUAdrE = eOp.adr;
    FlushM  = eOp.flushM;
    FlushW  = mOp.flushW;
    StallW  = mOp.stallW;
    if (mOp.flushM) mOp = '0;  // Flushed access is a bubble in M
    MemRWM     = mOp.rw;
    Funct3M    = mOp.f3;
    AtomicM    = mOp.atom;
    BigEndianM = mOp.be;
    WriteDataM = mOp.data;
  endtask

  // Address and faults while the access sits in M
  task automatic checkM(opT op);
    logic mis;
    mis = isMisaligned(op);
    if (op.flushM) begin
      checkWord("flushed IEUAdrM", '0, IEUAdrM);
    end else begin
      checkWord($sformatf("IEUAdrM @%0h", op.adr), op.adr, IEUAdrM);
      checkFlag($sformatf("load fault @%0h", op.adr), mis & op.rw.read & ~op.rw.write,
                LoadMisalignedFaultM);
      checkFlag($sformatf("store fault @%0h", op.adr), mis & op.rw.write,
                StoreAmoMisalignedFaultM);
    end
  endtask

  // W results, model updated in program order
  task automatic retireOp(opT op);
    logic mis;
    logic isSc;
    logic scOk;
    lsuPkg::xWordT expected;
    mis  = isMisaligned(op);
    isSc = op.rw.write && op.atom == lsuPkg::atomSc;
    scOk = resValid && (resDword == op.adr[lsuPkg::Xlen-1:3]);
    if (op.flushM) begin
      lastValid = 1'b0;
    end else if (op.stallW) begin
      if (lastValid) checkWord("held ReadDataW", lastRead, ReadDataW);
    end else begin
      checkFlag($sformatf("SquashSCW @%0h", op.adr), isSc & ~scOk, SquashSCW);
      if (isSc && !op.flushW) resValid = 1'b0;                 // Any SC drops the reservation
      if (op.rw.write && !mis && !op.flushW && (!isSc || scOk)) writeModel(op);
      if (op.rw.read && !op.rw.write && !mis) begin
        expected = modelLoad(op);
        checkWord($sformatf("ReadDataW @%0h", op.adr), expected, ReadDataW);
        lastRead  = expected;
        lastValid = 1'b1;
        if (op.atom == lsuPkg::atomLr && !op.flushW) begin
          resValid = 1'b1;
          resDword = op.adr[lsuPkg::Xlen-1:3];
        end
      end else begin
        lastValid = 1'b0;                                      // W now holds a don't-care
      end
    end
  endtask

  // Slot c drives op c into E and op c-1 into M, op c-2 is seen in W
  task automatic runOps();
    int n;
    opT idle;
    opT eOp;
    opT mOp;
    n    = ops.size();
    idle = '0;
    for (int c = 0; c <= n + 1; c++) begin
      @(negedge clk);
      if (c >= 2) retireOp(ops[c-2]);
      eOp = idle;
      mOp = idle;
      if (c < n) eOp = ops[c];
      if (c >= 1 && c <= n) mOp = ops[c-1];
      driveSlots(eOp, mOp);
      #2;                                          // Combinational M outputs settle
      if (c >= 1 && c <= n) checkM(ops[c-1]);
    end
    ops.delete();
  endtask

  task automatic waitResetClear();
    int i;
    for (i = 0; i < ResetTimeout; i++) begin
      if (IEUAdrM == '0 && ReadDataW == '0 && !SquashSCW) break;
      @(negedge clk);
    end
    if (i == ResetTimeout) begin
      errCount++;
      $display("Timeout: outputs did not clear after reset");
    end
  endtask

  task automatic startTest(string name);
    curTest  = name;
    errStart = errCount;
  endtask

  task automatic endTest();
    if (errCount == errStart) $display("test %s: ok", curTest);
    else $display("test %s: %0d errors", curTest, errCount - errStart);
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic testRoundTrip();
    startTest("doubleRoundTrip");
    for (int i = 0; i < 16; i++) pushStore(lsuPkg::sizeDouble, 1'b0, 8 * i, randWord());
    for (int i = 0; i < 16; i++) pushLoad(lsuPkg::sizeDouble, 1'b0, 1'b0, 8 * i); // Back to back
    runOps();
    endTest();
  endtask

  task automatic testSubword();
    lsuPkg::xWordT d;
    startTest("subword");
    d = randWord();
    d[7] = 1'b1;                                      // Negative byte
    pushStore(lsuPkg::sizeByte, 1'b0, 'h13, d);
    d = randWord();
    d[15] = 1'b1;
    pushStore(lsuPkg::sizeHalf, 1'b0, 'h1a, d);
    d = randWord();
    d[31] = 1'b0;                                     // Positive word
    pushStore(lsuPkg::sizeWord, 1'b0, 'h24, d);
    pushLoad(lsuPkg::sizeByte, 1'b0, 1'b0, 'h13);
    pushLoad(lsuPkg::sizeByte, 1'b1, 1'b0, 'h13);
    pushLoad(lsuPkg::sizeHalf, 1'b0, 1'b0, 'h1a);
    pushLoad(lsuPkg::sizeHalf, 1'b1, 1'b0, 'h1a);
    pushLoad(lsuPkg::sizeWord, 1'b0, 1'b0, 'h24);
    pushLoad(lsuPkg::sizeWord, 1'b1, 1'b0, 'h24);
    for (int a = 'h10; a <= 'h20; a += 8) pushLoad(lsuPkg::sizeDouble, 1'b0, 1'b0, a); // Neighbours
    runOps();
    endTest();
  endtask

  task automatic testBigEndian();
    startTest("bigEndian");
    pushStore(lsuPkg::sizeDouble, 1'b1, 'h40, randWord());
    pushLoad(lsuPkg::sizeDouble, 1'b0, 1'b1, 'h40);
    pushLoad(lsuPkg::sizeDouble, 1'b0, 1'b0, 'h40); // Little-endian view is byte reversed
    pushStore(lsuPkg::sizeWord, 1'b1, 'h4c, randWord());
    pushLoad(lsuPkg::sizeWord, 1'b0, 1'b1, 'h4c);
    pushLoad(lsuPkg::sizeWord, 1'b1, 1'b1, 'h4c);
    pushLoad(lsuPkg::sizeDouble, 1'b0, 1'b0, 'h48);
    pushStore(lsuPkg::sizeHalf, 1'b1, 'h52, randWord());
    pushLoad(lsuPkg::sizeHalf, 1'b0, 1'b1, 'h52);
    pushStore(lsuPkg::sizeByte, 1'b1, 'h57, randWord());
    pushLoad(lsuPkg::sizeByte, 1'b1, 1'b1, 'h57);
    pushLoad(lsuPkg::sizeDouble, 1'b0, 1'b0, 'h50);
    runOps();
    endTest();
  endtask

  task automatic testMisaligned();
    startTest("misaligned");
    pushLoad(lsuPkg::sizeHalf, 1'b0, 1'b0, 'h61);
    pushLoad(lsuPkg::sizeWord, 1'b0, 1'b0, 'h62);
    pushLoad(lsuPkg::sizeDouble, 1'b0, 1'b0, 'h64);
    pushStore(lsuPkg::sizeHalf, 1'b0, 'h63, randWord());
    pushStore(lsuPkg::sizeWord, 1'b0, 'h66, randWord());
    pushStore(lsuPkg::sizeDouble, 1'b0, 'h6c, randWord());
    pushLoad(lsuPkg::sizeDouble, 1'b0, 1'b0, 'h60); // Memory untouched
    pushLoad(lsuPkg::sizeDouble, 1'b0, 1'b0, 'h68);
    runOps();
    endTest();
  endtask

  task automatic testLrSc();
    startTest("lrSc");
    pushOp(makeOp(RwRead, lsuPkg::sizeDouble, 1'b0, lsuPkg::atomLr, 1'b0, 'h70, '0));
    pushOp(makeOp(RwWrite, lsuPkg::sizeDouble, 1'b0, lsuPkg::atomSc, 1'b0, 'h70, randWord()));
    pushLoad(lsuPkg::sizeDouble, 1'b0, 1'b0, 'h70);
    pushOp(makeOp(RwWrite, lsuPkg::sizeDouble, 1'b0, lsuPkg::atomSc, 1'b0, 'h70, randWord()));
    pushOp(makeOp(RwRead, lsuPkg::sizeDouble, 1'b0, lsuPkg::atomLr, 1'b0, 'h70, '0));
    pushOp(makeOp(RwWrite, lsuPkg::sizeDouble, 1'b0, lsuPkg::atomSc, 1'b0, 'h78, randWord()));
    pushLoad(lsuPkg::sizeDouble, 1'b0, 1'b0, 'h70);
    pushLoad(lsuPkg::sizeDouble, 1'b0, 1'b0, 'h78);
    runOps();
    endTest();
  endtask

  task automatic testStallFlush();
    opT op;
    startTest("stallFlush");
    pushLoad(lsuPkg::sizeDouble, 1'b0, 1'b0, 'h08);
    pushIdle(1'b1);                                 // W frozen for two cycles
    pushIdle(1'b1);
    pushIdle(1'b0);
    op = makeOp(RwRead, lsuPkg::sizeDouble, 1'b0, lsuPkg::atomNone, 1'b0, 'h30, '0);
    op.flushM = 1'b1;
    pushOp(op);
    op = makeOp(RwWrite, lsuPkg::sizeDouble, 1'b0, lsuPkg::atomNone, 1'b0, 'h38, randWord());
    op.flushW = 1'b1;
    pushOp(op);
    pushLoad(lsuPkg::sizeDouble, 1'b0, 1'b0, 'h38);
    runOps();
    endTest();
  endtask

  initial begin
    arstN      = 1'b0;
    StallM     = 1'b0;
    FlushM     = 1'b0;
    StallW     = 1'b0;
    FlushW     = 1'b0;
    MemRWE     = '0;
    IEUAdrE    = '0;
    MemRWM     = '0;
    Funct3M    = '0;
    AtomicM    = lsuPkg::atomNone;
    BigEndianM = 1'b0;
    WriteDataM = '0;
    resValid   = 1'b0;
    resDword   = '0;
    lastRead   = '0;
    lastValid  = 1'b0;
    repeat (10) @(negedge clk);
    arstN = 1'b1;
    curTest = "reset";
    waitResetClear();
    testRoundTrip();
    testSubword();
    testBigEndian();
    testMisaligned();
    testLrSc();
    testStallFlush();
    assertFails = u_lsuTop.u_lsuCtrl.u_lsuCtrlChk.failCount;
    if (assertFails != 0) begin
      errCount += assertFails;
      $display("%0d assertion failures in the control unit", assertFails);
    end
    $display("checks %0d errors %0d", checkCount, errCount);
    if (errCount == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- files.f
hw/lsuPkg.sv
hw/lsuCtrl.sv
hw/storeFormat.sv
hw/loadFormat.sv
hw/dtim.sv
hw/lsuTop.sv
sim/lsuCtrl_chk.sv
sim/lsuTb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := lsuTb
FILELIST  := files.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := ALL CHECKS PASSED

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the result, not the simulator exit code
sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
